//--- verilog/tinker_pkg.sv
`default_nettype none

package tinker_pkg;

    // -------------------------------------------------------------------------
    // widths
    // -------------------------------------------------------------------------

    // data and address word
    typedef logic [63:0] word_t;
    // instruction word
    typedef logic [31:0] inst_t;
    // register index, 32 registers
    typedef logic [4:0]  reg_idx_t;
    // instruction literal, sign-extended when used as an operand
    typedef logic [11:0] literal_t;

    // -------------------------------------------------------------------------
    // opcodes, kept subset only
    // -------------------------------------------------------------------------

    // anything not listed decodes as a no-op
    typedef enum logic [4:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,
        OP_SHFTR  = 5'h04,
        OP_SHFTRI = 5'h05,
        OP_SHFTL  = 5'h06,
        OP_SHFTLI = 5'h07,
        OP_JUMP   = 5'h08,
        OP_JUMPR  = 5'h09,
        OP_JUMPR2 = 5'h0A,
        OP_BRNZ   = 5'h0B,
        OP_BRGT   = 5'h0E,
        OP_HALT   = 5'h0F,
        OP_LOAD   = 5'h10,
        OP_MOV    = 5'h11,
        OP_MOVL   = 5'h12,
        OP_STORE  = 5'h13,
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,
        OP_SUB    = 5'h1A,
        OP_SUBI   = 5'h1B
    } opcode_t;

    // field positions (lsb of each field)
    localparam int OPCODE_LSB = 27;
    localparam int RD_LSB     = 22;
    localparam int RS_LSB     = 17;
    localparam int RT_LSB     = 12;
    localparam int LIT_LSB    = 0;

    // pc step
    localparam int INST_BYTES = 4;

    // true when operand two is the literal instead of rt
    function automatic logic uses_literal(opcode_t op);
        case (op)
            OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI,
            OP_MOVL, OP_JUMPR2, OP_LOAD, OP_STORE: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- verilog/exec_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface exec_bus_if
    import tinker_pkg::*;
();
    // one decoded instruction per cycle, no handshake
    logic     valid;
    opcode_t  opcode;
    reg_idx_t rd_idx;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    literal_t literal;
    // pc of the instruction itself
    word_t    pc;
    // register file values read in decode
    word_t    rd_val;
    word_t    rs_val;
    word_t    rt_val;

    modport source (
        output valid, opcode, rd_idx, rs_idx, rt_idx, literal, pc,
        output rd_val, rs_val, rt_val
    );

    modport sink (
        input valid, opcode, rd_idx, rs_idx, rt_idx, literal, pc,
        input rd_val, rs_val, rt_val
    );
endinterface

`default_nettype wire

//--- verilog/reg_read_if.sv
`timescale 1ns/1ps
`default_nettype none

interface reg_read_if
    import tinker_pkg::*;
();
    // three read ports, answered combinationally
    reg_idx_t rd_idx;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rd_val;
    word_t    rs_val;
    word_t    rt_val;

    modport initiator (output rd_idx, rs_idx, rt_idx, input rd_val, rs_val, rt_val);
    modport target (input rd_idx, rs_idx, rt_idx, output rd_val, rs_val, rt_val);
endinterface

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file
    import tinker_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    reg_read_if.target rd,
    input  logic       wb_write,
    input  reg_idx_t   wb_idx,
    input  word_t      wb_data
);
    localparam int NUM_REGS = 2 ** $bits(reg_idx_t);

    word_t regs [NUM_REGS];

    // write-through, same-cycle write wins over the stored word
    function automatic word_t read_port(reg_idx_t idx);
        if (wb_write && (wb_idx == idx)) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rd.rd_val = read_port(rd.rd_idx);
        rd.rs_val = read_port(rd.rs_idx);
        rd.rt_val = read_port(rd.rt_idx);
    end

    // all registers ordinary, r0 included
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write) begin
            regs[wb_idx] <= wb_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_decode.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_decode
    import tinker_pkg::*;
#(
    parameter word_t RESET_PC = 64'h2000
) (
    input  logic          clk,
    input  logic          reset,
    output word_t         imem_addr,
    input  inst_t         imem_data,
    reg_read_if.initiator rf,
    exec_bus_if.source    bus,
    input  logic          redirect,
    input  logic          halt_req,
    input  word_t         target
);
    word_t pc;
    inst_t ir;
    word_t ir_pc;
    logic  ir_valid;
    // set by halt, cleared only by reset
    logic  stopped;

    opcode_t  dec_opcode;
    literal_t dec_literal;

    // -------------------------------------------------------------------------
    // fetch
    // -------------------------------------------------------------------------

    assign imem_addr = pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc       <= RESET_PC;
            ir_valid <= 1'b0;
            stopped  <= 1'b0;
        end else if (halt_req || stopped) begin
            // pc frozen, only bubbles from here on
            ir_valid <= 1'b0;
            stopped  <= 1'b1;
        end else if (redirect) begin
            // word on imem is wrong path, drop it
            pc       <= target;
            ir_valid <= 1'b0;
        end else begin
            pc       <= pc + word_t'(INST_BYTES);
            ir_valid <= 1'b1;
        end
    end

    // fetched word and its pc
    always_ff @(posedge clk) begin
        ir    <= imem_data;
        ir_pc <= pc;
    end

    // -------------------------------------------------------------------------
    // decode and register read
    // -------------------------------------------------------------------------

    assign dec_opcode  = opcode_t'(ir[OPCODE_LSB +: $bits(opcode_t)]);
    assign dec_literal = ir[LIT_LSB +: $bits(literal_t)];
    assign rf.rd_idx   = ir[RD_LSB +: $bits(reg_idx_t)];
    assign rf.rs_idx   = ir[RS_LSB +: $bits(reg_idx_t)];
    assign rf.rt_idx   = ir[RT_LSB +: $bits(reg_idx_t)];

    // decode slot turns into a bubble on redirect or halt
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bus.valid <= 1'b0;
        end else begin
            bus.valid <= ir_valid && !redirect && !halt_req;
        end
    end

    always_ff @(posedge clk) begin
        bus.opcode  <= dec_opcode;
        bus.rd_idx  <= rf.rd_idx;
        bus.rs_idx  <= rf.rs_idx;
        bus.rt_idx  <= rf.rt_idx;
        bus.literal <= dec_literal;
        bus.pc      <= ir_pc;
        bus.rd_val  <= rf.rd_val;
        bus.rs_val  <= rf.rs_val;
        bus.rt_val  <= rf.rt_val;
    end

endmodule

`default_nettype wire

//--- verilog/alu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module alu_datapath
    import tinker_pkg::*;
(
    input  opcode_t  opcode,
    // rs, or forwarded rs
    input  word_t    op_a,
    // rt or sign-extended literal
    input  word_t    op_b,
    input  word_t    rd_val,
    input  literal_t literal,
    output word_t    result,
    output word_t    mem_addr,
    output logic     writes_reg,
    output logic     writes_mem
);
    // store addresses off rd, load off rs
    assign mem_addr = (opcode == OP_STORE) ? rd_val + op_b : op_a + op_b;

    always_comb begin
        result     = '0;
        writes_reg = 1'b1;
        writes_mem = 1'b0;
        case (opcode)
            OP_AND:    result = op_a & op_b;
            OP_OR:     result = op_a | op_b;
            OP_XOR:    result = op_a ^ op_b;
            OP_NOT:    result = ~op_a;
            OP_SHFTR,
            OP_SHFTRI: result = op_a >> op_b;
            OP_SHFTL,
            OP_SHFTLI: result = op_a << op_b;
            OP_ADD:    result = op_a + op_b;
            OP_SUB:    result = op_a - op_b;
            // immediate add/sub work on rd
            OP_ADDI:   result = rd_val + op_b;
            OP_SUBI:   result = rd_val - op_b;
            OP_MOV:    result = op_a;
            // low 12 bits replaced, upper rd kept
            OP_MOVL:   result = {rd_val[$bits(word_t)-1:$bits(literal_t)], literal};
            // value comes from dmem in writeback
            OP_LOAD:   result = '0;
            OP_STORE: begin
                writes_reg = 1'b0;
                writes_mem = 1'b1;
            end
            // branches, halt, unknown
            default:   writes_reg = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module branch_resolve
    import tinker_pkg::*;
(
    input  opcode_t opcode,
    input  word_t   pc,
    input  word_t   op_a,
    input  word_t   op_b,
    input  word_t   rd_val,
    output logic    taken,
    output logic    halt,
    output word_t   target
);
    always_comb begin
        taken  = 1'b0;
        halt   = 1'b0;
        // absolute target in rd unless relative
        target = rd_val;
        case (opcode)
            OP_JUMP:   taken = 1'b1;
            OP_JUMPR: begin
                taken  = 1'b1;
                target = pc + rd_val;
            end
            // op_b holds the sign-extended literal here
            OP_JUMPR2: begin
                taken  = 1'b1;
                target = pc + op_b;
            end
            OP_BRNZ:   taken = (op_a != '0);
            // signed compare rs > rt
            OP_BRGT:   taken = ($signed(op_a) > $signed(op_b));
            OP_HALT:   halt = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import tinker_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    exec_bus_if.sink bus,
    output logic     redirect,
    output logic     halt_req,
    output word_t    target,
    output logic     wb_write,
    output reg_idx_t wb_idx,
    output word_t    wb_data,
    output word_t    dmem_addr,
    output word_t    dmem_wdata,
    output logic     dmem_write,
    input  word_t    dmem_rdata,
    output logic     hlt
);
    word_t rd_fwd;
    word_t rs_fwd;
    word_t rt_fwd;
    word_t lit_ext;
    word_t op_b;

    word_t alu_result;
    word_t alu_mem_addr;
    logic  alu_writes_reg;
    logic  alu_writes_mem;
    logic  br_taken;
    logic  br_halt;
    word_t br_target;

    // writeback register, beyond the ones on output ports
    word_t wb_value;
    logic  wb_load;

    // -------------------------------------------------------------------------
    // operand forwarding
    // -------------------------------------------------------------------------

    // only the writeback slot can be newer than the decode read
    function automatic word_t forward(reg_idx_t idx, word_t reg_val);
        return (wb_write && (wb_idx == idx)) ? wb_data : reg_val;
    endfunction

    always_comb begin
        rd_fwd = forward(bus.rd_idx, bus.rd_val);
        rs_fwd = forward(bus.rs_idx, bus.rs_val);
        rt_fwd = forward(bus.rt_idx, bus.rt_val);
    end

    assign lit_ext = word_t'($signed(bus.literal));
    assign op_b    = uses_literal(bus.opcode) ? lit_ext : rt_fwd;

    alu_datapath u_alu (
        .opcode     (bus.opcode),
        .op_a       (rs_fwd),
        .op_b       (op_b),
        .rd_val     (rd_fwd),
        .literal    (bus.literal),
        .result     (alu_result),
        .mem_addr   (alu_mem_addr),
        .writes_reg (alu_writes_reg),
        .writes_mem (alu_writes_mem)
    );

    branch_resolve u_branch (
        .opcode (bus.opcode),
        .pc     (bus.pc),
        .op_a   (rs_fwd),
        .op_b   (op_b),
        .rd_val (rd_fwd),
        .taken  (br_taken),
        .halt   (br_halt),
        .target (br_target)
    );

    // bubbles never redirect or stop fetch
    assign redirect = bus.valid && br_taken;
    assign halt_req = bus.valid && br_halt;
    assign target   = br_target;

    // -------------------------------------------------------------------------
    // writeback register
    // -------------------------------------------------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_write   <= 1'b0;
            wb_load    <= 1'b0;
            dmem_write <= 1'b0;
            hlt        <= 1'b0;
        end else begin
            wb_write   <= bus.valid && alu_writes_reg;
            wb_load    <= bus.valid && (bus.opcode == OP_LOAD);
            dmem_write <= bus.valid && alu_writes_mem;
            // sticky until reset
            if (halt_req) begin
                hlt <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_idx     <= bus.rd_idx;
        wb_value   <= alu_result;
        dmem_addr  <= alu_mem_addr;
        // store data is rs
        dmem_wdata <= rs_fwd;
    end

    // load data arrives combinationally from dmem
    assign wb_data = wb_load ? dmem_rdata : wb_value;

endmodule

`default_nettype wire

//--- verilog/tinker_core.sv
`timescale 1ns/1ps
`default_nettype none

module tinker_core
    import tinker_pkg::*;
#(
    parameter word_t RESET_PC = 64'h2000
) (
    input  logic  clk,
    input  logic  reset,
    // instruction port
    output word_t imem_addr,
    input  inst_t imem_data,
    // data port, accessed from writeback
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_write,
    input  word_t dmem_rdata,
    output logic  hlt
);
    logic     wb_write;
    reg_idx_t wb_idx;
    word_t    wb_data;
    logic     redirect;
    logic     halt_req;
    word_t    target;

    exec_bus_if exec_bus ();
    reg_read_if rf_read ();

    fetch_decode #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .rf        (rf_read),
        .bus       (exec_bus),
        .redirect  (redirect),
        .halt_req  (halt_req),
        .target    (target)
    );

    register_file u_rf (
        .clk      (clk),
        .reset    (reset),
        .rd       (rf_read),
        .wb_write (wb_write),
        .wb_idx   (wb_idx),
        .wb_data  (wb_data)
    );

    execute_stage u_exec (
        .clk        (clk),
        .reset      (reset),
        .bus        (exec_bus),
        .redirect   (redirect),
        .halt_req   (halt_req),
        .target     (target),
        .wb_write   (wb_write),
        .wb_idx     (wb_idx),
        .wb_data    (wb_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_write (dmem_write),
        .dmem_rdata (dmem_rdata),
        .hlt        (hlt)
    );

endmodule

`default_nettype wire

//--- verification/tinker_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module tinker_core_assertions
    import tinker_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  hlt,
    input logic  dmem_write,
    input word_t imem_addr
);
    // bumped on every assertion failure, watched from the testbench
    int failed_checks = 0;

    // outputs quiet on the first edge out of reset
    reset_quiet: assert property (@(posedge clk) $fell(reset) |-> !hlt && !dmem_write)
        else begin
            failed_checks++;
            $error("hlt or dmem_write high right after reset");
        end

    // hlt is sticky until the next reset
    halt_sticky: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
        else begin
            failed_checks++;
            $error("hlt fell while out of reset");
        end

    // fetch stays word aligned
    fetch_aligned: assert property (@(posedge clk) disable iff (reset) imem_addr[1:0] == 2'b00)
        else begin
            failed_checks++;
            $error("imem_addr not a multiple of four");
        end

    // nothing reaches memory once halted
    quiet_after_halt: assert property (@(posedge clk) disable iff (reset) hlt |-> !dmem_write)
        else begin
            failed_checks++;
            $error("dmem_write high after hlt");
        end

endmodule

bind tinker_core tinker_core_assertions u_assertions (
    .clk        (clk),
    .reset      (reset),
    .hlt        (hlt),
    .dmem_write (dmem_write),
    .imem_addr  (imem_addr)
);

`default_nettype wire

//--- verification/tb_tinker_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tinker_core
    import tinker_pkg::*;
();
    localparam word_t RESET_PC     = 64'h4000;
    localparam int    CLK_PERIOD   = 20;
    localparam int    RESET_CYCLES = 2;
    localparam int    PROG_MAX     = 128;
    localparam int    DMEM_WORDS   = 256;
    localparam int    EXP_MAX      = 64;
    // answered past the end of the program
    localparam inst_t HALT_WORD    = {OP_HALT, 27'd0};

    logic  clk;
    logic  reset;
    word_t imem_addr;
    inst_t imem_data;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_write;
    word_t dmem_rdata;
    logic  hlt;

    inst_t  prog [PROG_MAX];
    int     prog_len = 0;
    word_t  dmem [DMEM_WORDS];
    integer seed;

    // expected stores in program order
    word_t exp_addr [EXP_MAX];
    word_t exp_data [EXP_MAX];
    int    exp_count = 0;
    int    store_idx;

    word_t fetch_word_idx;

    tinker_core #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_write (dmem_write),
        .dmem_rdata (dmem_rdata),
        .hlt        (hlt)
    );

    // ---------------------------------------------------------------------------
    // combinational memory models
    // ---------------------------------------------------------------------------

    assign fetch_word_idx = (imem_addr - RESET_PC) >> 2;
    assign imem_data = (fetch_word_idx < word_t'(prog_len)) ? prog[fetch_word_idx[6:0]]
                                                           : HALT_WORD;
    assign dmem_rdata = dmem[dmem_addr[10:3]];

    always @(posedge clk) begin
        if (dmem_write) begin
            dmem[dmem_addr[10:3]] <= dmem_wdata;
        end
    end

    // ---------------------------------------------------------------------------
    // helpers
    // ---------------------------------------------------------------------------

    task automatic end_in_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic put_inst(opcode_t op, int rd, int rs, int rt, int lit);
        prog[prog_len] = {op, reg_idx_t'(rd), reg_idx_t'(rs), reg_idx_t'(rt), literal_t'(lit)};
        prog_len++;
    endtask

    // wrong-path store that must never show up on dmem
    task automatic put_marker();
        put_inst(OP_STORE, 0, 1, 0, 'h7F0);
    endtask

    task automatic expect_store(word_t addr, word_t data);
        exp_addr[exp_count] = addr;
        exp_data[exp_count] = data;
        exp_count++;
    endtask

    function automatic word_t pc_of(int idx);
        return RESET_PC + word_t'(idx * INST_BYTES);
    endfunction

    // ---------------------------------------------------------------------------
    // test program with instruction indices noted where a branch needs them
    // ---------------------------------------------------------------------------

    task automatic build_program();
        // two loads with the second used right away
        put_inst(OP_LOAD, 1, 0, 0, 'h000);
        put_inst(OP_LOAD, 2, 0, 0, 'h008);
        // register chain where each uses the previous result
        put_inst(OP_ADD, 3, 1, 2, 0);
        put_inst(OP_SUB, 4, 3, 1, 0);
        put_inst(OP_AND, 5, 4, 2, 0);
        put_inst(OP_OR, 6, 5, 1, 0);
        put_inst(OP_XOR, 7, 6, 3, 0);
        put_inst(OP_NOT, 8, 7, 0, 0);
        put_inst(OP_ADDI, 9, 0, 0, 'h005);
        put_inst(OP_SHFTR, 10, 8, 9, 0);
        put_inst(OP_SHFTL, 11, 10, 9, 0);
        put_inst(OP_MOV, 12, 11, 0, 0);
        for (int k = 3; k <= 12; k++) begin
            put_inst(OP_STORE, 0, k, 0, 'h400 + 8 * (k - 3));
        end
        // literal forms
        put_inst(OP_ADDI, 13, 0, 0, 'hFF0);
        // rs nonzero so that only rd gives the right result
        put_inst(OP_SUBI, 14, 9, 0, 'h823);
        put_inst(OP_SHFTRI, 15, 2, 0, 'h00C);
        put_inst(OP_SHFTLI, 16, 15, 0, 'h007);
        put_inst(OP_MOV, 17, 1, 0, 0);
        put_inst(OP_MOVL, 17, 0, 0, 'hABC);
        for (int k = 13; k <= 17; k++) begin
            put_inst(OP_STORE, 0, k, 0, 'h400 + 8 * (k - 3));
        end
        // memory with a nonzero base and a load feeding a store
        put_inst(OP_ADDI, 18, 0, 0, 'h100);
        put_inst(OP_STORE, 18, 1, 0, 'h380);
        put_inst(OP_LOAD, 19, 18, 0, 'h010);
        put_inst(OP_STORE, 0, 19, 0, 'h488);
        // jump to index 43
        put_inst(OP_ADDI, 20, 0, 0, int'(RESET_PC >> 12));
        put_inst(OP_SHFTLI, 20, 20, 0, 'h00C);
        put_inst(OP_ADDI, 20, 0, 0, 43 * 4);
        put_inst(OP_JUMP, 20, 0, 0, 0);
        put_marker();
        put_marker();
        put_inst(OP_STORE, 0, 20, 0, 'h490);
        // jump rel from 45 to 48
        put_inst(OP_ADDI, 21, 0, 0, 'h00C);
        put_inst(OP_JUMPR, 21, 0, 0, 0);
        put_marker();
        put_marker();
        put_inst(OP_STORE, 0, 21, 0, 'h498);
        // jump rel2 from 49 to 52
        put_inst(OP_JUMPR2, 0, 0, 0, 'h00C);
        put_marker();
        put_marker();
        put_inst(OP_STORE, 0, 2, 0, 'h4A0);
        // brnz taken to 58 and then not taken
        put_inst(OP_MOV, 22, 20, 0, 0);
        put_inst(OP_ADDI, 22, 0, 0, (58 - 43) * 4);
        put_inst(OP_BRNZ, 22, 9, 0, 0);
        put_marker();
        put_marker();
        put_inst(OP_STORE, 0, 22, 0, 'h4A8);
        put_inst(OP_BRNZ, 22, 0, 0, 0);
        put_inst(OP_STORE, 0, 9, 0, 'h4B0);
        // brgt taken (5 > -3) to 67 and then not taken (-3 > 5)
        put_inst(OP_MOV, 24, 22, 0, 0);
        put_inst(OP_ADDI, 24, 0, 0, (67 - 58) * 4);
        put_inst(OP_ADDI, 23, 0, 0, 'hFFD);
        put_inst(OP_BRGT, 24, 9, 23, 0);
        put_marker();
        put_marker();
        put_inst(OP_STORE, 0, 23, 0, 'h4B8);
        put_inst(OP_BRGT, 24, 23, 9, 0);
        put_inst(OP_STORE, 0, 24, 0, 'h4C0);
        put_inst(OP_HALT, 0, 0, 0, 0);
        // squashed behind the halt
        put_marker();
        put_marker();
    endtask

    // expected values straight from the instruction rules
    task automatic build_expected();
        word_t m0;
        word_t m1;
        word_t m34;
        word_t x [32];
        m0    = dmem[0];
        m1    = dmem[1];
        m34   = dmem['h110 / 8];
        x[3]  = m0 + m1;
        x[4]  = x[3] - m0;
        x[5]  = x[4] & m1;
        x[6]  = x[5] | m0;
        x[7]  = x[6] ^ x[3];
        x[8]  = ~x[7];
        x[9]  = 64'd5;
        x[10] = x[8] >> 5;
        x[11] = x[10] << 5;
        x[12] = x[11];
        // 0 + sext(0xff0)
        x[13] = 64'hFFFF_FFFF_FFFF_FFF0;
        // rd still zero minus sext(0x823)
        x[14] = 64'd2013;
        x[15] = m1 >> 12;
        x[16] = x[15] << 7;
        // low 12 bits replaced
        x[17] = {m0[63:12], 12'hABC};
        for (int k = 3; k <= 17; k++) begin
            expect_store(64'h400 + word_t'(8 * (k - 3)), x[k]);
        end
        expect_store(64'h480, m0);
        expect_store(64'h488, m34);
        expect_store(64'h490, pc_of(43));
        expect_store(64'h498, 64'd12);
        expect_store(64'h4A0, m1);
        expect_store(64'h4A8, pc_of(58));
        expect_store(64'h4B0, 64'd5);
        expect_store(64'h4B8, 64'hFFFF_FFFF_FFFF_FFFD);
        expect_store(64'h4C0, pc_of(67));
    endtask

    // ---------------------------------------------------------------------------
    // clock, setup, reset and end of run
    // ---------------------------------------------------------------------------

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        seed = 32'h5b5f;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = {$random(seed), $random(seed)};
        end
        build_program();
        build_expected();
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        while (hlt !== 1'b1) @(negedge clk);
        // a few more cycles for the halt checks
        repeat (4) @(negedge clk);
        if (store_idx == exp_count) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("Fail at %0t: %0d of %0d stores seen", $time, store_idx, exp_count);
            end_in_failure();
        end
    end

    // program built at time 0
    initial begin
        #1;
        repeat (4 * prog_len + RESET_CYCLES) @(posedge clk);
        $display("watchdog expired before the core halted with all stores seen");
        end_in_failure();
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            store_idx <= 0;
        end else if (dmem_write) begin
            store_idx <= store_idx + 1;
        end
    end

    always @(UUT.u_assertions.failed_checks) begin
        if (UUT.u_assertions.failed_checks != 0) begin
            $display("a bound protocol assertion on tinker_core failed");
            end_in_failure();
        end
    end

    // ---------------------------------------------------------------------------
    // checks
    // ---------------------------------------------------------------------------

    reset_pc_check: assert property (@(posedge clk) $fell(reset) |-> imem_addr == RESET_PC)
        else begin
            $display("Fail at %0t: imem_addr %h after reset", $time, $sampled(imem_addr));
            end_in_failure();
        end

    // each store against the next expected entry
    store_check: assert property (@(posedge clk) disable iff (reset)
        dmem_write |-> (store_idx < exp_count) && (dmem_addr == exp_addr[store_idx])
                       && (dmem_wdata == exp_data[store_idx]))
        else begin
            $display("Fail at %0t: store %0d addr %h data %h", $time, $sampled(store_idx),
                     $sampled(dmem_addr), $sampled(dmem_wdata));
            end_in_failure();
        end

    // all stores in before the core sits halted
    halt_count_check: assert property (@(posedge clk) disable iff (reset)
        (hlt && !dmem_write) |-> store_idx == exp_count)
        else begin
            $display("Fail at %0t: halted after %0d of %0d stores", $time,
                     $sampled(store_idx), exp_count);
            end_in_failure();
        end

    // fetch frozen once halted
    halt_fetch_check: assert property (@(posedge clk) disable iff (reset)
        hlt |-> $stable(imem_addr))
        else begin
            $display("Fail at %0t: imem_addr moved to %h after hlt", $time,
                     $sampled(imem_addr));
            end_in_failure();
        end

endmodule

`default_nettype wire

//--- vlog.f
verilog/tinker_pkg.sv
verilog/exec_bus_if.sv
verilog/reg_read_if.sv
verilog/register_file.sv
verilog/fetch_decode.sv
verilog/alu_datapath.sv
verilog/branch_resolve.sv
verilog/execute_stage.sv
verilog/tinker_core.sv
verification/tinker_core_assertions.sv
verification/tb_tinker_core.sv

//--- Bender.yml
package:
  name: tinker_core

sources:
  - files:
      - verilog/tinker_pkg.sv
      - verilog/exec_bus_if.sv
      - verilog/reg_read_if.sv
      - verilog/register_file.sv
      - verilog/fetch_decode.sv
      - verilog/alu_datapath.sv
      - verilog/branch_resolve.sv
      - verilog/execute_stage.sv
      - verilog/tinker_core.sv
  - target: simulation
    files:
      - verification/tinker_core_assertions.sv
      - verification/tb_tinker_core.sv
